// File: vit_config.svh
`ifndef VIT_CONFIG_SVH
`define VIT_CONFIG_SVH

// trellis size for K=5
`define VIT_STATES  16
`define VIT_STATE_W 4

// radix-4 steps per frame, two info bits each
`define VIT_STEPS   32

`define VIT_PM_W    8   // path metric width

// wishbone word addresses
`define VIT_ADR_CODE0 0
`define VIT_ADR_CODE1 1
`define VIT_ADR_CODE2 2
`define VIT_ADR_CODE3 3
`define VIT_ADR_CTRL  4
`define VIT_ADR_STAT  5
`define VIT_ADR_DATA0 6
`define VIT_ADR_DATA1 7

`endif

// File: vit_pkg.sv
`include "vit_config.svh"

package vit_pkg;

    // one received code word, seen by the host as raw bits
    // and by the decode stage as eight 4-bit quads
    typedef union packed {
        logic [31:0]      raw;
        logic [7:0][3:0]  quad;   // quad[q] is step q of this word
    } code_word_u;

    // per-step record between stages
    typedef struct packed {
        logic                                  valid;
        logic [4:0]                            idx;   // radix-4 step index
        logic [3:0]                            quad;  // received code bits
        logic [`VIT_STATES-1:0][3:0][2:0]      bm;    // per state, per predecessor choice
    } step_t;

    // wishbone classic request from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [5:0] rsvd;   // reads as zero
        logic       done;
        logic       busy;
    } stat_t;

endpackage

// File: vit_wb_regs.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_wb_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  vit_pkg::wb_req_t             i_wb,
    output logic [31:0]                  o_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_start,
    output vit_pkg::code_word_u [3:0]    o_code,
    input  logic                         i_tb_done,
    input  logic [63:0]                  i_tb_data,
    output vit_pkg::stat_t               o_stat
);

    logic                       access;
    logic                       wr;
    logic [31:0]                rd_mux;
    logic                       busy_q;
    logic                       done_q;
    logic [63:0]                dec_q;
    vit_pkg::code_word_u [3:0]  code_q;

    assign access = i_wb.cyc & i_wb.stb & ~o_wb_ack;   // ack drops for a cycle after each access
    assign wr     = access & i_wb.we;

    assign o_stat = '{rsvd: '0, done: done_q, busy: busy_q};
    assign o_code = code_q;

    // read path, write-only registers give zero
    always_comb
    begin
        case (i_wb.adr)
            3'(`VIT_ADR_STAT):  rd_mux = {24'd0, o_stat};
            3'(`VIT_ADR_DATA0): rd_mux = dec_q[31:0];
            3'(`VIT_ADR_DATA1): rd_mux = dec_q[63:32];
            default:            rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= 32'd0;
            o_start  <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            dec_q    <= 64'd0;
        end
        else
        begin
            o_wb_ack <= access;
            o_start  <= 1'b0;
            if (access && !i_wb.we)
                o_wb_dat <= rd_mux;
            // start is refused while a frame is in flight
            if (wr && i_wb.adr == 3'(`VIT_ADR_CTRL) && i_wb.dat[0] && !busy_q)
            begin
                o_start <= 1'b1;
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
            end
            if (i_tb_done)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
                dec_q  <= i_tb_data;
            end
        end
    end

    // code words, addresses 0..3
    always_ff @(posedge clk)
    begin
        if (wr && i_wb.adr[2] == 1'b0)
            code_q[i_wb.adr[1:0]].raw <= i_wb.dat;
    end

    a_ack_gap: assert property (@(posedge clk) disable iff (!rst)
        o_wb_ack |=> !o_wb_ack);

endmodule

// File: vit_branch_metric.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_branch_metric (
    input  logic            clk,
    input  logic            rst,
    input  vit_pkg::step_t  i_step,
    output vit_pkg::step_t  o_step
);

    localparam logic [4:0] G0 = 5'o23;
    localparam logic [4:0] G1 = 5'o35;

    logic                               valid_q;
    logic [4:0]                         idx_q;
    logic [`VIT_STATES-1:0][3:0][2:0]   bm_d;
    logic [`VIT_STATES-1:0][3:0][2:0]   bm_q;

    // r = {choice, next state} with r[0] the newest input bit
    always_comb
    begin : bm_calc
        logic [5:0] r;
        logic [4:0] w1;
        logic [4:0] w2;
        logic [3:0] diff;
        for (int s = 0; s < `VIT_STATES; s++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                r = 6'(c * `VIT_STATES + s);
                for (int j = 0; j < 5; j++)
                begin
                    w1[j] = r[5 - j];   // first stage window with w[4] newest
                    w2[j] = r[4 - j];
                end
                diff = {^(w2 & G1), ^(w2 & G0), ^(w1 & G1), ^(w1 & G0)} ^ i_step.quad;
                bm_d[s][c] = 3'(diff[0]) + 3'(diff[1]) + 3'(diff[2]) + 3'(diff[3]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            valid_q <= 1'b0;
        else
            valid_q <= i_step.valid;
    end

    always_ff @(posedge clk)
    begin
        idx_q <= i_step.idx;
        bm_q  <= bm_d;
    end

    assign o_step = '{valid: valid_q, idx: idx_q, quad: '0, bm: bm_q};

endmodule

// File: vit_acs.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_acs (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_start,
    input  vit_pkg::step_t                               i_step,
    output logic                                         o_wr_en,
    output logic [4:0]                                   o_wr_step,
    output logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]     o_wr_row,
    output logic                                         o_frame_end
);

    localparam logic [`VIT_PM_W-1:0] PM_INIT = `VIT_PM_W'(64);   // large start for states != 0

    logic [`VIT_STATES-1:0][`VIT_PM_W-1:0]     pm_q;
    logic [`VIT_STATES-1:0][`VIT_PM_W-1:0]     pm_nxt;
    logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]  surv;

    // predecessors of s are {c, s[3:2]} for c = 0..3
    always_comb
    begin : acs_calc
        logic [`VIT_STATE_W-1:0] p;
        logic [`VIT_PM_W-1:0]    sum;
        for (int s = 0; s < `VIT_STATES; s++)
        begin
            pm_nxt[s] = '0;
            surv[s]   = '0;
            for (int c = 0; c < 4; c++)
            begin
                p   = `VIT_STATE_W'(c * 4 + s / 4);
                sum = pm_q[p] + `VIT_PM_W'(i_step.bm[s][c]);
                if (c == 0 || sum < pm_nxt[s])   // strict compare keeps lowest on tie
                begin
                    pm_nxt[s] = sum;
                    surv[s]   = p;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            for (int s = 0; s < `VIT_STATES; s++)
                pm_q[s] <= (s == 0) ? '0 : PM_INIT;   // encoder starts in state 0
        end
        else if (i_step.valid)
        begin
            pm_q <= pm_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            o_frame_end <= 1'b0;
        else
            o_frame_end <= i_step.valid && i_step.idx == 5'(`VIT_STEPS - 1);
    end

    assign o_wr_en   = i_step.valid;
    assign o_wr_step = i_step.idx;
    assign o_wr_row  = surv;

    // frame end trails start by 32 steps plus feed and metric latency
    a_frame_end: assert property (@(posedge clk) disable iff (!rst)
        o_frame_end |-> $past(o_wr_en && o_wr_step == 5'(`VIT_STEPS - 1))
                        && $past(i_start, `VIT_STEPS + 2));

endmodule

// File: vit_survivor_mem.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_survivor_mem (
    input  logic                                         clk,
    input  logic                                         i_wr_en,
    input  logic [4:0]                                   i_wr_step,
    input  logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]     i_wr_row,
    input  logic [4:0]                                   i_rd_step,
    output logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]     o_rd_row
);

    // one row per step, each entry is the winning predecessor of that state
    logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0] mem [`VIT_STEPS];

    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[i_wr_step] <= i_wr_row;
    end

    assign o_rd_row = mem[i_rd_step];   // async read, traceback steps once per cycle

endmodule

// File: vit_traceback.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_traceback (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_frame_end,
    output logic [4:0]                                   o_rd_step,
    input  logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]     i_rd_row,
    output logic                                         o_done,
    output logic [63:0]                                  o_data
);

    logic                    active_q;
    logic [4:0]              cnt_q;
    logic [`VIT_STATE_W-1:0] st_q;
    logic                    run;
    logic [4:0]              step_cur;
    logic [`VIT_STATE_W-1:0] st_cur;

    // frame end reads step 31 from state 0 in the same cycle
    assign run      = i_frame_end | active_q;
    assign step_cur = active_q ? cnt_q : 5'(`VIT_STEPS - 1);
    assign st_cur   = active_q ? st_q : '0;   // zero tail ends the trellis in state 0

    assign o_rd_step = step_cur;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            st_q     <= '0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (run)
            begin
                st_q <= i_rd_row[st_cur];   // step back to the stored predecessor
                if (step_cur == 5'd0)
                begin
                    active_q <= 1'b0;
                    o_done   <= 1'b1;
                end
                else
                begin
                    active_q <= 1'b1;
                    cnt_q    <= step_cur - 5'd1;
                end
            end
        end
    end

    // low two state bits are the two info bits of this step
    always_ff @(posedge clk)
    begin
        if (run)
        begin
            o_data[{step_cur, 1'b0}] <= st_cur[1];
            o_data[{step_cur, 1'b1}] <= st_cur[0];
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        o_done |=> !o_done);

endmodule

// File: vit_top.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_top (
    input  logic              clk,
    input  logic              rst,
    input  vit_pkg::wb_req_t  i_wb,
    output logic [31:0]       o_wb_dat,
    output logic              o_wb_ack
);

    logic                                        start;
    vit_pkg::code_word_u [3:0]                   code;
    vit_pkg::stat_t                              stat;
    logic                                        tb_done;
    logic [63:0]                                 tb_data;
    logic                                        feed_active_q;
    logic [4:0]                                  feed_cnt_q;
    vit_pkg::step_t                              feed_step;
    vit_pkg::step_t                              bm_step;
    logic                                        wr_en;
    logic [4:0]                                  wr_step;
    logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]    wr_row;
    logic                                        frame_end;
    logic [4:0]                                  rd_step;
    logic [`VIT_STATES-1:0][`VIT_STATE_W-1:0]    rd_row;

    vit_wb_regs u_regs (
        .clk(clk), .rst(rst), .i_wb(i_wb), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .o_start(start), .o_code(code), .i_tb_done(tb_done), .i_tb_data(tb_data),
        .o_stat(stat)
    );

    // one quad per cycle, starting the cycle after start
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            feed_active_q <= 1'b0;
            feed_cnt_q    <= '0;
        end
        else if (start)
        begin
            feed_active_q <= 1'b1;
            feed_cnt_q    <= '0;
        end
        else if (feed_active_q)
        begin
            feed_cnt_q <= feed_cnt_q + 5'd1;
            if (feed_cnt_q == 5'(`VIT_STEPS - 1))
                feed_active_q <= 1'b0;
        end
    end

    // word step/8, quad step mod 8
    assign feed_step = '{valid: feed_active_q, idx: feed_cnt_q,
                         quad: code[feed_cnt_q[4:3]].quad[feed_cnt_q[2:0]], bm: '0};

    vit_branch_metric u_bm (.clk(clk), .rst(rst), .i_step(feed_step), .o_step(bm_step));

    vit_acs u_acs (
        .clk(clk), .rst(rst), .i_start(start), .i_step(bm_step), .o_wr_en(wr_en),
        .o_wr_step(wr_step), .o_wr_row(wr_row), .o_frame_end(frame_end)
    );

    vit_survivor_mem u_mem (
        .clk(clk), .i_wr_en(wr_en), .i_wr_step(wr_step), .i_wr_row(wr_row),
        .i_rd_step(rd_step), .o_rd_row(rd_row)
    );

    vit_traceback u_tb (
        .clk(clk), .rst(rst), .i_frame_end(frame_end), .o_rd_step(rd_step),
        .i_rd_row(rd_row), .o_done(tb_done), .o_data(tb_data)
    );

    // the register file only waits on traceback while busy
    a_done_busy: assert property (@(posedge clk) disable iff (!rst)
        tb_done |-> stat.busy);

endmodule

// File: vit_tb.sv
`timescale 1ns/1ps
`include "vit_config.svh"

module vit_tb;

    localparam int CLK_HALF    = 20;
    localparam int ACK_LIMIT   = 8;
    localparam int POLL_LIMIT  = 200;
    localparam int WATCHDOG_NS = 20 * 200 * 40;   // 20 frames of 200 cycles at 40 ns

    logic             clk;
    logic             rst;
    vit_pkg::wb_req_t wb_req;
    logic [31:0]      wb_dat;
    logic             wb_ack;
    logic [31:0]      lcg_state;
    logic [63:0]      exp_q[$];
    logic [63:0]      got_q[$];
    int               n_frames;
    int               n_checked;

    vit_top UUT (.clk(clk), .rst(rst), .i_wb(wb_req), .o_wb_dat(wb_dat), .o_wb_ack(wb_ack));

    always #(CLK_HALF) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_stat(input string name, input vit_pkg::stat_t got,
                              input vit_pkg::stat_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] t=%0t %s: got busy=%b done=%b (%h), expected busy=%b done=%b (%h)",
                     $time, name, got.busy, got.done, got, exp.busy, exp.done, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // 32-bit LCG with numerical recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] random_info();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = next_rand();
        hi = next_rand();
        return {4'd0, hi[27:0], lo};   // zero tail
    endfunction

    function automatic vit_pkg::stat_t make_stat(input logic busy, input logic done);
        return '{rsvd: '0, done: done, busy: busy};
    endfunction

    // rate 1/2 encoder with g0 = 23 and g1 = 35 octal
    // msb of each generator taps the newest bit
    // info bit t gives code bit 2t (g0) and 2t+1 (g1) as in the quad layout
    function automatic logic [127:0] encode_frame(input logic [63:0] info);
        logic [127:0] code;
        logic [63:0]  u;
        logic [4:0]   sr;   // sr[0] newest and sr[4] oldest
        code = '0;
        sr   = '0;
        u    = {4'd0, info[59:0]};
        for (int t = 0; t < 64; t++)
        begin
            sr = {sr[3:0], u[t]};
            code[2 * t]     = sr[0] ^ sr[3] ^ sr[4];           // 1 + D^3 + D^4
            code[2 * t + 1] = sr[0] ^ sr[1] ^ sr[2] ^ sr[4];   // 1 + D + D^2 + D^4
        end
        return code;
    endfunction

    // single classic cycle held until ack
    task automatic bus_access(input logic we, input int adr, input logic [31:0] dat,
                              output logic [31:0] rd);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: 3'(adr), dat: dat};
        @(posedge clk);
        #1;
        while (!wb_ack)
        begin
            if (waited == ACK_LIMIT)
                abort_run("bus access was never acknowledged");
            waited++;
            @(posedge clk);
            #1;
        end
        rd     = wb_dat;
        wb_req = '0;
    endtask

    task automatic bus_write(input int adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input int adr, output logic [31:0] rd);
        bus_access(1'b0, adr, 32'd0, rd);
    endtask

    task automatic expect_stat(input logic busy, input logic done);
        logic [31:0] rd;
        bus_read(`VIT_ADR_STAT, rd);
        check_word("status upper bits", {8'd0, rd[31:8]}, 32'd0);
        check_stat("status", vit_pkg::stat_t'(rd[7:0]), make_stat(busy, done));
    endtask

    task automatic load_code(input logic [127:0] code);
        for (int w = 0; w < 4; w++)
            bus_write(`VIT_ADR_CODE0 + w, code[32 * w +: 32]);
    endtask

    task automatic start_frame();
        bus_write(`VIT_ADR_CTRL, 32'd1);
        expect_stat(1'b1, 1'b0);   // busy right away and old done cleared
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        int          polls;
        polls = 0;
        rd    = '0;
        while (rd[1] !== 1'b1)   // done bit
        begin
            if (polls == POLL_LIMIT)
                abort_run("done never set after start");
            bus_read(`VIT_ADR_STAT, rd);
            polls++;
        end
        check_stat("status at done", vit_pkg::stat_t'(rd[7:0]), make_stat(1'b0, 1'b1));
    endtask

    task automatic collect_result(input logic [63:0] exp);
        logic [31:0] d0;
        logic [31:0] d1;
        bus_read(`VIT_ADR_DATA0, d0);
        bus_read(`VIT_ADR_DATA1, d1);
        exp_q.push_back(exp);
        got_q.push_back({d1, d0});
        n_frames++;
    endtask

    // flips land 40 bits apart plus a small random offset
    task automatic decode_frame(input logic [63:0] info, input int flips);
        logic [127:0] code;
        int           pos;
        code = encode_frame(info);
        for (int i = 0; i < flips; i++)
        begin
            pos       = 40 * i + int'(next_rand() & 32'd7);
            code[pos] = ~code[pos];
        end
        load_code(code);
        start_frame();
        wait_done();
        collect_result(info);
    endtask

    always @(posedge clk)
    begin : compare
        logic [63:0] got;
        logic [63:0] exp;
        if (got_q.size() != 0)
        begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_data("decoded data", got, exp);
            n_checked++;
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timed out waiting for done");
        $display("Result: FAILED");
        $fatal(1);
    end

    initial
    begin : stimulus
        logic [63:0] info;
        logic [63:0] other;
        logic [31:0] rd;
        logic [31:0] junk;
        clk       = 1'b0;
        rst       = 1'b0;
        wb_req    = '0;
        lcg_state = 32'hdb9f_0649;
        n_frames  = 0;
        n_checked = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;

        expect_stat(1'b0, 1'b0);
        bus_read(`VIT_ADR_DATA0, rd);
        check_word("data0 after reset", rd, 32'd0);
        bus_read(`VIT_ADR_DATA1, rd);
        check_word("data1 after reset", rd, 32'd0);

        repeat (10) decode_frame(random_info(), 0);
        repeat (5) decode_frame(random_info(), 3);   // within correction power of dfree 7

        // second start while busy must be refused
        info  = random_info();
        other = random_info();
        load_code(encode_frame(info));
        start_frame();
        repeat (`VIT_STEPS + 4) @(posedge clk);   // feed is past the last quad
        load_code(encode_frame(other));            // would be decoded by a second run
        bus_write(`VIT_ADR_CTRL, 32'd1);
        expect_stat(1'b1, 1'b0);
        wait_done();
        collect_result(info);
        repeat (100) @(posedge clk);
        expect_stat(1'b0, 1'b1);   // no second run

        // read-only registers ignore writes
        junk = next_rand();
        bus_write(`VIT_ADR_STAT, junk);
        bus_write(`VIT_ADR_DATA0, junk);
        bus_write(`VIT_ADR_DATA1, ~junk);
        expect_stat(1'b0, 1'b1);
        bus_read(`VIT_ADR_DATA0, rd);
        check_word("data0 after write", rd, info[31:0]);
        bus_read(`VIT_ADR_DATA1, rd);
        check_word("data1 after write", rd, {4'd0, info[59:32]});
        for (int a = `VIT_ADR_CODE0; a <= `VIT_ADR_CTRL; a++)
        begin
            bus_read(a, rd);
            check_word("write-only register read", rd, 32'd0);
        end

        while (got_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
        if (n_checked == n_frames && n_frames == 16)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d decoded frames were compared", n_checked, n_frames);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

// File: vit_top.f
+incdir+.
vit_pkg.sv
vit_wb_regs.sv
vit_branch_metric.sv
vit_acs.sv
vit_survivor_mem.sv
vit_traceback.sv
vit_top.sv
vit_tb.sv

// File: Makefile
# Verilator build and run of the Viterbi decoder testbench

TOP := vit_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): vit_top.f vit_config.svh $(wildcard *.sv)
	verilator --binary --timing --assert -f vit_top.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f vit_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
